// ==== src/tcdm_pkg.sv ====
// Shared memory cluster definitions

`default_nettype none

package tcdm_pkg;

  // Cluster sizes
  localparam int unsigned NumCores       = 4;
  localparam int unsigned BankingFactor  = 2;
  localparam int unsigned NumBanks       = NumCores * BankingFactor;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned BeWidth        = DataWidth / 8;
  localparam int unsigned BankWords      = 64;
  localparam int unsigned NumOutstanding = 2;

  // Derived index widths
  localparam int unsigned CoreIdWidth = $clog2(NumCores);
  localparam int unsigned BankIdWidth = $clog2(NumBanks);
  localparam int unsigned RowWidth    = $clog2(BankWords);

  // Address map: byte offset, then bank select, then row
  localparam int unsigned ByteOffset = $clog2(BeWidth);
  localparam int unsigned RowOffset  = ByteOffset + BankIdWidth;

  // Response buffer sizing
  localparam int unsigned PtrWidth = (NumOutstanding > 1) ? $clog2(NumOutstanding) : 1;
  localparam int unsigned CntWidth = $clog2(NumOutstanding + 1);

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [BeWidth-1:0]     strb_t;
  typedef logic [CoreIdWidth-1:0] core_id_t;
  typedef logic [BankIdWidth-1:0] bank_id_t;
  typedef logic [RowWidth-1:0]    bank_addr_t;

  // FIFO slot index and outstanding count
  typedef logic [PtrWidth-1:0]    fifo_ptr_t;
  typedef logic [CntWidth-1:0]    resp_cnt_t;

endpackage : tcdm_pkg

`default_nettype wire

// ==== src/bank_arbiter.sv ====
// Round-robin bank arbiter

`default_nettype none
`timescale 1ns/1ps

module bank_arbiter import tcdm_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NumCores-1:0] req_i,
  output logic [NumCores-1:0] gnt_o,
  output core_id_t            winner_o
);

  // First core to look at in the next search
  core_id_t ptr_q;
  core_id_t idx;
  logic     found;

  // Search from the pointer, wrapping around the cores
  always_comb begin
    gnt_o    = '0;
    winner_o = ptr_q;
    found    = 1'b0;
    idx      = ptr_q;
    for (int i = 0; i < NumCores; i++) begin
      idx = core_id_t'((int'(ptr_q) + i) % NumCores);
      if (!found && req_i[idx]) begin
        found    = 1'b1;
        winner_o = idx;
      end
    end
    gnt_o[winner_o] = found;
  end

  // Move past the winner, hold when nothing is granted
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= core_id_t'((int'(winner_o) + 1) % NumCores);
    end
  end

endmodule : bank_arbiter

`default_nettype wire

// ==== src/tcdm_bank.sv ====
// TCDM memory bank

`default_nettype none
`timescale 1ns/1ps

module tcdm_bank import tcdm_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Request from the interconnect
  input  logic       req_i,
  input  bank_addr_t row_i,
  input  core_id_t   ini_i,
  input  logic       wen_i,
  input  data_t      wdata_i,
  input  strb_t      be_i,
  // Read response, one cycle after the request
  output logic       vld_o,
  output core_id_t   resp_ini_o,
  output data_t      rdata_o
);

  data_t    mem [BankWords];

  logic     vld_q;
  core_id_t ini_q;
  data_t    rdata_q;

  // Byte-enable write port
  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      for (int k = 0; k < BeWidth; k++) begin
        if (be_i[k]) begin
          mem[row_i][8*k +: 8] <= wdata_i[8*k +: 8];
        end
      end
    end
  end

  // Read data and initiator tag
  always_ff @(posedge clk_i) begin
    if (req_i && !wen_i) begin
      rdata_q <= mem[row_i];
      ini_q   <= ini_i;
    end
  end

  // Response valid, only for reads
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= req_i && !wen_i;
    end
  end

  assign vld_o      = vld_q;
  assign resp_ini_o = ini_q;
  assign rdata_o    = rdata_q;

endmodule : tcdm_bank

`default_nettype wire

// ==== src/resp_buffer.sv ====
// Core response buffer with read credits

`default_nettype none
`timescale 1ns/1ps

module resp_buffer import tcdm_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // A read was granted to this core
  input  logic  read_grant_i,
  // Routed bank response
  input  logic  push_i,
  input  data_t data_i,
  output logic  credit_ok_o,
  // Core side
  output logic  vld_o,
  input  logic  rdy_i,
  output data_t rdata_o
);

  data_t     fifo_q [NumOutstanding];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  resp_cnt_t fill_q;
  resp_cnt_t credit_q;
  logic      pop;

  assign pop = vld_o && rdy_i;

  // Storage, overflow is ruled out by the credit check
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      fifo_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      credit_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_t'(NumOutstanding - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_t'(NumOutstanding - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      // Reads in flight, from grant until delivery
      case ({read_grant_i, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign credit_ok_o = credit_q < resp_cnt_t'(NumOutstanding);
  assign vld_o       = fill_q != '0;
  assign rdata_o     = fifo_q[rd_ptr_q];

endmodule : resp_buffer

`default_nettype wire

// ==== src/tcdm_interconnect.sv ====
// Variable latency core to bank interconnect

`default_nettype none
`timescale 1ns/1ps

module tcdm_interconnect import tcdm_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Core requests
  input  logic       [NumCores-1:0]  req_i,
  input  addr_t      [NumCores-1:0]  addr_i,
  input  logic       [NumCores-1:0]  wen_i,
  input  data_t      [NumCores-1:0]  wdata_i,
  input  strb_t      [NumCores-1:0]  be_i,
  output logic       [NumCores-1:0]  gnt_o,
  // Bank requests
  output logic       [NumBanks-1:0]  bank_req_o,
  output bank_addr_t [NumBanks-1:0]  bank_row_o,
  output core_id_t   [NumBanks-1:0]  bank_ini_o,
  output logic       [NumBanks-1:0]  bank_wen_o,
  output data_t      [NumBanks-1:0]  bank_wdata_o,
  output strb_t      [NumBanks-1:0]  bank_be_o,
  // Bank responses
  input  logic       [NumBanks-1:0]  bank_vld_i,
  input  core_id_t   [NumBanks-1:0]  bank_resp_ini_i,
  input  data_t      [NumBanks-1:0]  bank_rdata_i,
  // Response buffers
  input  logic       [NumCores-1:0]  credit_ok_i,
  output logic       [NumCores-1:0]  resp_push_o,
  output data_t      [NumCores-1:0]  resp_data_o,
  output logic       [NumCores-1:0]  read_grant_o
);

  bank_id_t   [NumCores-1:0]                core_bank;
  bank_addr_t [NumCores-1:0]                core_row;
  logic       [NumCores-1:0]                core_req;
  logic       [NumBanks-1:0][NumCores-1:0]  arb_req;
  logic       [NumBanks-1:0][NumCores-1:0]  arb_gnt;
  core_id_t   [NumBanks-1:0]                arb_winner;

  // Address decode, and reads held back without credit
  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      core_bank[c] = addr_i[c][ByteOffset +: BankIdWidth];
      core_row[c]  = addr_i[c][RowOffset +: RowWidth];
      core_req[c]  = req_i[c] && (wen_i[c] || credit_ok_i[c]);
    end
  end

  // Request matrix, one row per bank
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int c = 0; c < NumCores; c++) begin
        arb_req[b][c] = core_req[c] && (core_bank[c] == bank_id_t'(b));
      end
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    bank_arbiter i_arbiter (
      .clk_i   (clk_i        ),
      .rst_n_i (rst_n_i      ),
      .req_i   (arb_req[b]   ),
      .gnt_o   (arb_gnt[b]   ),
      .winner_o(arb_winner[b])
    );

    // Winner payload to the bank
    assign bank_req_o[b]   = |arb_gnt[b];
    assign bank_ini_o[b]   = arb_winner[b];
    assign bank_row_o[b]   = core_row[arb_winner[b]];
    assign bank_wen_o[b]   = wen_i[arb_winner[b]];
    assign bank_wdata_o[b] = wdata_i[arb_winner[b]];
    assign bank_be_o[b]    = be_i[arb_winner[b]];
  end : gen_banks

  // A core targets one bank, so at most one row grants it
  always_comb begin
    gnt_o = '0;
    for (int b = 0; b < NumBanks; b++) begin
      gnt_o = gnt_o | arb_gnt[b];
    end
  end

  assign read_grant_o = gnt_o & ~wen_i;

  // Route bank responses back by initiator tag
  always_comb begin
    resp_push_o = '0;
    resp_data_o = '0;
    for (int c = 0; c < NumCores; c++) begin
      for (int b = 0; b < NumBanks; b++) begin
        if (bank_vld_i[b] && (bank_resp_ini_i[b] == core_id_t'(c))) begin
          resp_push_o[c] = 1'b1;
          resp_data_o[c] = bank_rdata_i[b];
        end
      end
    end
  end

endmodule : tcdm_interconnect

`default_nettype wire

// ==== src/tcdm_cluster.sv ====
// Shared memory cluster top level

`default_nettype none
`timescale 1ns/1ps

module tcdm_cluster import tcdm_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Core request ports
  input  logic  [NumCores-1:0]  req_i,
  input  addr_t [NumCores-1:0]  addr_i,
  input  logic  [NumCores-1:0]  wen_i,
  input  data_t [NumCores-1:0]  wdata_i,
  input  strb_t [NumCores-1:0]  be_i,
  output logic  [NumCores-1:0]  gnt_o,
  // Core response ports
  output logic  [NumCores-1:0]  vld_o,
  input  logic  [NumCores-1:0]  rdy_i,
  output data_t [NumCores-1:0]  rdata_o
);

  logic       [NumBanks-1:0] bank_req;
  bank_addr_t [NumBanks-1:0] bank_row;
  core_id_t   [NumBanks-1:0] bank_ini;
  logic       [NumBanks-1:0] bank_wen;
  data_t      [NumBanks-1:0] bank_wdata;
  strb_t      [NumBanks-1:0] bank_be;
  logic       [NumBanks-1:0] bank_vld;
  core_id_t   [NumBanks-1:0] bank_resp_ini;
  data_t      [NumBanks-1:0] bank_rdata;

  logic       [NumCores-1:0] credit_ok;
  logic       [NumCores-1:0] resp_push;
  data_t      [NumCores-1:0] resp_data;
  logic       [NumCores-1:0] read_grant;

  tcdm_interconnect i_interco (
    .clk_i          (clk_i        ),
    .rst_n_i        (rst_n_i      ),
    .req_i          (req_i        ),
    .addr_i         (addr_i       ),
    .wen_i          (wen_i        ),
    .wdata_i        (wdata_i      ),
    .be_i           (be_i         ),
    .gnt_o          (gnt_o        ),
    .bank_req_o     (bank_req     ),
    .bank_row_o     (bank_row     ),
    .bank_ini_o     (bank_ini     ),
    .bank_wen_o     (bank_wen     ),
    .bank_wdata_o   (bank_wdata   ),
    .bank_be_o      (bank_be      ),
    .bank_vld_i     (bank_vld     ),
    .bank_resp_ini_i(bank_resp_ini),
    .bank_rdata_i   (bank_rdata   ),
    .credit_ok_i    (credit_ok    ),
    .resp_push_o    (resp_push    ),
    .resp_data_o    (resp_data    ),
    .read_grant_o   (read_grant   )
  );

  for (genvar c = 0; c < NumCores; c++) begin : gen_resp
    resp_buffer i_resp_buffer (
      .clk_i       (clk_i        ),
      .rst_n_i     (rst_n_i      ),
      .read_grant_i(read_grant[c]),
      .push_i      (resp_push[c] ),
      .data_i      (resp_data[c] ),
      .credit_ok_o (credit_ok[c] ),
      .vld_o       (vld_o[c]     ),
      .rdy_i       (rdy_i[c]     ),
      .rdata_o     (rdata_o[c]   )
    );
  end : gen_resp

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i     (clk_i           ),
      .rst_n_i   (rst_n_i         ),
      .req_i     (bank_req[b]     ),
      .row_i     (bank_row[b]     ),
      .ini_i     (bank_ini[b]     ),
      .wen_i     (bank_wen[b]     ),
      .wdata_i   (bank_wdata[b]   ),
      .be_i      (bank_be[b]      ),
      .vld_o     (bank_vld[b]     ),
      .resp_ini_o(bank_resp_ini[b]),
      .rdata_o   (bank_rdata[b]   )
    );
  end : gen_bank

endmodule : tcdm_cluster

`default_nettype wire

// ==== tests/tb_tcdm_tasks.svh ====
// TCDM testbench model and helpers

`ifndef TB_TCDM_TASKS_SVH
`define TB_TCDM_TASKS_SVH

// Reference memory by bank and row
data_t ref_mem [NumBanks][BankWords];

// Expected read data per core, oldest first
data_t exp_q [NumCores][$];
data_t exp_head [NumCores];
int    exp_cnt [NumCores];

int err_cnt;
int test_cnt;

// Bits 4:2 pick the bank, bits 10:5 the row
function automatic addr_t make_addr(input int bank, input int row);
  addr_t a;
  a = '0;
  a[4:2] = bank[2:0];
  a[10:5] = row[5:0];
  return a;
endfunction

// Byte-enable merge into the model
function automatic void ref_write(input addr_t addr, input data_t wdata, input strb_t be);
  for (int k = 0; k < 4; k++) begin
    if (be[k]) begin
      ref_mem[addr[4:2]][addr[10:5]][8*k +: 8] = wdata[8*k +: 8];
    end
  end
endfunction

// Drive one request and hold it until granted
task automatic issue_req(input int c, input logic wen, input addr_t addr,
                         input data_t wdata, input strb_t be, input int max_cycles);
  int waited;
  waited = 0;
  @(negedge clk_i);
  req_i[c]   = 1'b1;
  wen_i[c]   = wen;
  addr_i[c]  = addr;
  wdata_i[c] = wdata;
  be_i[c]    = be;
  @(posedge clk_i);
  while (!gnt_o[c] && waited < max_cycles) begin
    waited++;
    @(posedge clk_i);
  end
  if (!gnt_o[c]) begin
    err_cnt++;
    $display("Core %0d request to %h was not granted within %0d cycles", c, addr, max_cycles);
    @(negedge clk_i);
    req_i[c] = 1'b0;
  end
endtask

task automatic release_core(input int c);
  @(negedge clk_i);
  req_i[c] = 1'b0;
endtask

// Wait until every granted read has been delivered
task automatic wait_drain(input int max_cycles);
  int waited;
  int pending;
  waited = 0;
  pending = 1;
  while (pending != 0 && waited <= max_cycles) begin
    @(negedge clk_i);
    waited++;
    pending = 0;
    for (int c = 0; c < NumCores; c++) begin
      pending += exp_cnt[c];
    end
  end
  if (pending != 0) begin
    err_cnt++;
    $display("%0d read responses still missing after %0d cycles", pending, max_cycles);
  end
endtask

task automatic end_test(input string name, input int errs_before);
  test_cnt++;
  if (err_cnt == errs_before) begin
    $display("Test %0d %s: ok", test_cnt, name);
  end else begin
    $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
  end
endtask

`endif

// ==== tests/tb_tcdm_cluster.sv ====
// TCDM cluster testbench

`default_nettype none
`timescale 1ns/1ps

module tb_tcdm_cluster import tcdm_pkg::*; ();

  logic                 clk_i;
  logic                 rst_n_i;
  logic  [NumCores-1:0] req_i;
  addr_t [NumCores-1:0] addr_i;
  logic  [NumCores-1:0] wen_i;
  data_t [NumCores-1:0] wdata_i;
  strb_t [NumCores-1:0] be_i;
  logic  [NumCores-1:0] gnt_o;
  logic  [NumCores-1:0] vld_o;
  logic  [NumCores-1:0] rdy_i;
  data_t [NumCores-1:0] rdata_o;

  // Round-robin window for one watched bank
  logic           fair_on;
  bank_id_t       fair_bank;
  core_id_t [3:0] fair_win;
  int             fair_cnt;
  logic           fair_ok;
  logic           bank_clash;
  int             streams_done;

  `include "tb_tcdm_tasks.svh"

  tcdm_cluster DUT (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .req_i  (req_i  ),
    .addr_i (addr_i ),
    .wen_i  (wen_i  ),
    .wdata_i(wdata_i),
    .be_i   (be_i   ),
    .gnt_o  (gnt_o  ),
    .vld_o  (vld_o  ),
    .rdy_i  (rdy_i  ),
    .rdata_o(rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Model update on every grant and response transfer
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < NumCores; c++) begin
        exp_q[c].delete();
      end
    end else begin
      for (int c = 0; c < NumCores; c++) begin
        if (vld_o[c] && rdy_i[c] && exp_q[c].size() > 0) begin
          void'(exp_q[c].pop_front());
        end
        if (gnt_o[c] && wen_i[c]) begin
          ref_write(addr_i[c], wdata_i[c], be_i[c]);
        end else if (gnt_o[c]) begin
          exp_q[c].push_back(ref_mem[addr_i[c][4:2]][addr_i[c][10:5]]);
        end
        if (fair_on && gnt_o[c] && addr_i[c][4:2] == fair_bank) begin
          fair_win = {fair_win[2:0], core_id_t'(c)};
          fair_cnt++;
        end
      end
    end
    for (int c = 0; c < NumCores; c++) begin
      exp_cnt[c]  = exp_q[c].size();
      exp_head[c] = (exp_q[c].size() > 0) ? exp_q[c][0] : '0;
    end
  end

  always_comb begin
    fair_ok = 1'b1;
    for (int i = 0; i < 4; i++) begin
      for (int j = i + 1; j < 4; j++) begin
        if (fair_win[i] == fair_win[j]) begin
          fair_ok = 1'b0;
        end
      end
    end
  end

  // Grants per bank decoded from the core addresses
  always_comb begin
    int n;
    bank_clash = 1'b0;
    for (int b = 0; b < NumBanks; b++) begin
      n = 0;
      for (int c = 0; c < NumCores; c++) begin
        if (gnt_o[c] && addr_i[c][4:2] == b[2:0]) begin
          n++;
        end
      end
      if (n > 1) begin
        bank_clash = 1'b1;
      end
    end
  end

  for (genvar c = 0; c < NumCores; c++) begin : gen_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      vld_o[c] && rdy_i[c] |-> rdata_o[c] == exp_head[c])
    else begin
      err_cnt++;
      $display("** Error: rdata_o[%0d] expected %h, got %h",
               c, $sampled(exp_head[c]), $sampled(rdata_o[c]));
    end
    assert property (@(posedge clk_i) disable iff (!rst_n_i) vld_o[c] |-> exp_cnt[c] > 0)
    else begin
      err_cnt++;
      $display("Core %0d raised vld_o with no read pending", c);
    end
    assert property (@(posedge clk_i) disable iff (!rst_n_i) exp_cnt[c] <= NumOutstanding)
    else begin
      err_cnt++;
      $display("Core %0d has %0d reads pending, more than the limit of %0d",
               c, $sampled(exp_cnt[c]), NumOutstanding);
    end
  end : gen_check

  assert property (@(posedge clk_i) disable iff (!rst_n_i) (gnt_o & ~req_i) == '0)
  else begin
    err_cnt++;
    $display("** Error: gnt_o %h is high for a core whose req_i %h is low",
             $sampled(gnt_o), $sampled(req_i));
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) !bank_clash)
  else begin
    err_cnt++;
    $display("Two cores were granted the same bank in one cycle");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) fair_on && fair_cnt >= 4 |-> fair_ok)
  else begin
    err_cnt++;
    $display("Grants to bank %0d left round-robin order", fair_bank);
  end

  // Back-to-back reads to one bank
  task automatic read_stream(input int c, input int bank, input int n);
    for (int i = 0; i < n; i++) begin
      issue_req(c, 1'b0, make_addr(bank, i % 2), '0, '0, 40);
    end
    release_core(c);
  endtask

  // Mixed traffic inside rows 8+4c to 11+4c of every bank
  task automatic random_stream(input int c, input int n);
    int bank;
    int row;
    for (int r = 0; r < 4; r++) begin
      for (int b = 0; b < NumBanks; b++) begin
        issue_req(c, 1'b1, make_addr(b, 8 + 4*c + r), $urandom, 4'hf, 200);
      end
    end
    for (int i = 0; i < n; i++) begin
      bank = $urandom_range(NumBanks - 1);
      row  = 8 + 4*c + $urandom_range(3);
      issue_req(c, logic'($urandom_range(1)), make_addr(bank, row), $urandom,
                strb_t'($urandom), 200);
    end
    release_core(c);
    streams_done++;
  endtask

  initial begin
    int errs;
    int spins;
    void'($urandom(32'hcdf2c7f9));
    err_cnt = 0;
    test_cnt = 0;
    fair_on = 1'b0;
    fair_bank = 3'd3;
    fair_win = '0;
    fair_cnt = 0;
    streams_done = 0;
    rst_n_i = 1'b0;
    req_i = '0;
    addr_i = '0;
    wen_i = '0;
    wdata_i = '0;
    be_i = '0;
    rdy_i = '1;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;

    errs = err_cnt;
    repeat (20) @(negedge clk_i);
    end_test("idle after reset", errs);

    errs = err_cnt;
    for (int b = 0; b < NumBanks; b++) begin
      issue_req(0, 1'b1, make_addr(b, 0), $urandom, 4'hf, 20);
    end
    for (int b = 0; b < NumBanks; b++) begin
      issue_req(0, 1'b0, make_addr(b, 0), '0, '0, 20);
    end
    release_core(0);
    wait_drain(50);
    end_test("full word read-back", errs);

    errs = err_cnt;
    for (int b = 0; b < NumBanks; b++) begin
      issue_req(0, 1'b1, make_addr(b, 1), $urandom, 4'hf, 20);
    end
    for (int b = 0; b < NumBanks; b++) begin
      issue_req(0, 1'b1, make_addr(b, 1), $urandom, strb_t'($urandom), 20);
    end
    for (int b = 0; b < NumBanks; b++) begin
      issue_req(0, 1'b0, make_addr(b, 1), '0, '0, 20);
    end
    release_core(0);
    wait_drain(50);
    end_test("byte enables", errs);

    errs = err_cnt;
    fair_cnt = 0;
    fair_on = 1'b1;
    fork
      read_stream(0, 3, 12);
      read_stream(1, 3, 12);
      read_stream(2, 3, 12);
      read_stream(3, 3, 12);
    join
    fair_on = 1'b0;
    wait_drain(50);
    end_test("round-robin on one bank", errs);

    // Core 1 stops taking responses, so its credits run out
    errs = err_cnt;
    rdy_i[1] = 1'b0;
    issue_req(1, 1'b0, make_addr(2, 0), '0, '0, 20);
    issue_req(1, 1'b0, make_addr(5, 1), '0, '0, 20);
    issue_req(1, 1'b1, make_addr(6, 0), $urandom, 4'hf, 20);
    fork
      issue_req(1, 1'b0, make_addr(6, 0), '0, '0, 40);
      begin
        repeat (8) @(negedge clk_i);
        rdy_i[1] = 1'b1;
      end
    join
    release_core(1);
    wait_drain(50);
    end_test("read back-pressure", errs);

    errs = err_cnt;
    spins = 0;
    fork
      random_stream(0, 40);
      random_stream(1, 40);
      random_stream(2, 40);
      random_stream(3, 40);
      begin
        while (streams_done < NumCores && spins < 50000) begin
          @(negedge clk_i);
          rdy_i = NumCores'($urandom);
          spins++;
        end
      end
    join
    rdy_i = '1;
    wait_drain(50);
    end_test("random traffic", errs);

    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_tcdm_cluster

`default_nettype wire

// ==== files.f ====
+incdir+tests
src/tcdm_pkg.sv
src/bank_arbiter.sv
src/tcdm_bank.sv
src/resp_buffer.sv
src/tcdm_interconnect.sv
src/tcdm_cluster.sv
tests/tb_tcdm_cluster.sv
